//--- psram_cfg.svh
`ifndef PSRAM_CFG_SVH
`define PSRAM_CFG_SVH

// pseudo-SRAM device
`define PSRAM_LATENCY 4
`define PSRAM_WORDS   64
`define PSRAM_DATA_W  16
`define PSRAM_ADDR_W  6

// command buffer and bursts
`define FIFO_DEPTH    16
`define MAX_BURST     8

`endif

//--- psram_pkg.sv
`include "psram_cfg.svh"

package psram_pkg;

    typedef logic [`PSRAM_ADDR_W-1:0] addr_t;
    typedef logic [`PSRAM_DATA_W-1:0] data_t;

    // counts the wait cycles after the address cycle
    typedef logic [1:0] lat_cnt_t;

    typedef enum logic [2:0] {
        mem_idle,
        mem_wait_rd,
        mem_data_rd,
        mem_wait_wr,
        mem_data_wr
    } mem_state_t;

endpackage

//--- burst_pkg.sv
`include "psram_cfg.svh"

package burst_pkg;

    typedef logic [3:0] blen_t;
    typedef logic [$clog2(`FIFO_DEPTH):0] level_t;
    typedef logic [`PSRAM_DATA_W-1:0] entry_t;

    typedef enum logic {kind_hdr, kind_data} entry_kind_t;

    typedef enum logic [2:0] {
        st_idle, st_wait_data, st_addr, st_latency, st_burst, st_release
    } ctrl_state_t;

    // header layout: write flag on top, length below it, address in the low bits
    localparam int hdr_wr_bit  = `PSRAM_DATA_W - 1;
    localparam int hdr_len_lsb = hdr_wr_bit - $bits(blen_t);

endpackage

//--- burst_fifo_if.sv
interface burst_fifo_if;

    logic                   push;
    burst_pkg::entry_kind_t push_kind;
    burst_pkg::entry_t      push_entry;
    burst_pkg::level_t      level;
    burst_pkg::entry_kind_t head_kind;
    burst_pkg::entry_t      head_entry;
    logic                   pop;

    modport producer (
        output push, push_kind, push_entry,
        input  level
    );

    modport buffer (
        input  push, push_kind, push_entry, pop,
        output level, head_kind, head_entry
    );

    modport consumer (
        input  level, head_kind, head_entry,
        output pop
    );

endinterface

//--- psram_if.sv
interface psram_if;

    psram_pkg::addr_t addr;
    logic             adv_n;
    logic             ce_n;
    logic             oe_n;
    logic             we_n;
    logic             wait_sig;

    // data bus split in place of a tristate pin
    psram_pkg::data_t dq_out;
    logic             dq_oe;
    psram_pkg::data_t dq_in;

    modport ctrl (
        output addr, adv_n, ce_n, oe_n, we_n,
        output dq_out, dq_oe,
        input  wait_sig, dq_in
    );

    modport mem (
        input  addr, adv_n, ce_n, oe_n, we_n,
        input  dq_out, dq_oe,
        output wait_sig, dq_in
    );

endinterface

//--- host_cmd_port.sv
`include "psram_cfg.svh"

module host_cmd_port (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  cmd_start,
    input  logic                  cmd_write,
    input  psram_pkg::addr_t      cmd_addr,
    input  burst_pkg::blen_t      cmd_len,
    input  logic                  wr_strobe,
    input  psram_pkg::data_t      wr_data,
    output logic                  busy,
    burst_fifo_if.producer        fifo
);

    logic                   push_q;
    burst_pkg::entry_kind_t kind_q;
    burst_pkg::entry_t      entry_q;
    burst_pkg::entry_t      hdr_entry;
    burst_pkg::blen_t       owed;
    burst_pkg::level_t      used;

    always_comb begin
        hdr_entry = '0;
        hdr_entry[burst_pkg::hdr_wr_bit] = cmd_write;
        hdr_entry[burst_pkg::hdr_len_lsb +: $bits(burst_pkg::blen_t)] = cmd_len;
        hdr_entry[`PSRAM_ADDR_W-1:0] = cmd_addr;
    end

    // a command and a write word never arrive in the same cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            push_q <= 1'b0;
            owed   <= '0;
        end else begin
            push_q <= cmd_start || wr_strobe;
            if (cmd_start && cmd_write) begin
                owed <= cmd_len;
            end else if (wr_strobe) begin
                owed <= owed - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_start) begin
            kind_q  <= burst_pkg::kind_hdr;
            entry_q <= hdr_entry;
        end else if (wr_strobe) begin
            kind_q  <= burst_pkg::kind_data;
            entry_q <= wr_data;
        end
    end

    assign fifo.push       = push_q;
    assign fifo.push_kind  = kind_q;
    assign fifo.push_entry = entry_q;

    // count the entry still in flight so a full burst always fits
    assign used = fifo.level + burst_pkg::level_t'(push_q);
    assign busy = used > burst_pkg::level_t'(`FIFO_DEPTH - `MAX_BURST - 1);

    a_start_busy : assert property (@(posedge clk) disable iff (!rst_n)
        cmd_start |-> !busy);
    a_start_owed : assert property (@(posedge clk) disable iff (!rst_n)
        cmd_start |-> owed == '0);
    a_len_range : assert property (@(posedge clk) disable iff (!rst_n)
        cmd_start |-> cmd_len >= 1 && cmd_len <= `MAX_BURST);
    a_strobe_owed : assert property (@(posedge clk) disable iff (!rst_n)
        wr_strobe |-> owed != '0);

endmodule

//--- burst_fifo.sv
`include "psram_cfg.svh"

module burst_fifo (
    input  logic         clk,
    input  logic         rst_n,
    burst_fifo_if.buffer fifo
);

    localparam int ptr_w = $clog2(`FIFO_DEPTH);

    burst_pkg::entry_t      entry_mem [`FIFO_DEPTH];
    burst_pkg::entry_kind_t kind_mem  [`FIFO_DEPTH];
    logic [ptr_w-1:0]       wr_ptr;
    logic [ptr_w-1:0]       rd_ptr;
    burst_pkg::level_t      level_q;

    always_ff @(posedge clk) begin
        if (fifo.push) begin
            entry_mem[wr_ptr] <= fifo.push_entry;
            kind_mem[wr_ptr]  <= fifo.push_kind;
        end
    end

    // pointers wrap on their own, depth is a power of two
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            level_q <= '0;
        end else begin
            if (fifo.push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (fifo.pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({fifo.push, fifo.pop})
                2'b10:   level_q <= level_q + 1'b1;
                2'b01:   level_q <= level_q - 1'b1;
                default: level_q <= level_q;
            endcase
        end
    end

    // head shows before the pop
    assign fifo.head_entry = entry_mem[rd_ptr];
    assign fifo.head_kind  = kind_mem[rd_ptr];
    assign fifo.level      = level_q;

    a_no_overflow : assert property (@(posedge clk) disable iff (!rst_n)
        fifo.push |-> level_q != burst_pkg::level_t'(`FIFO_DEPTH));
    a_no_underflow : assert property (@(posedge clk) disable iff (!rst_n)
        fifo.pop |-> level_q != '0);

endmodule

//--- psram_bus_ctrl.sv
`include "psram_cfg.svh"

module psram_bus_ctrl (
    input  logic              clk,
    input  logic              rst_n,
    burst_fifo_if.consumer    fifo,
    psram_if.ctrl             bus,
    output logic              rd_valid,
    output psram_pkg::data_t  rd_data
);

    burst_pkg::ctrl_state_t state;
    logic                   wr_q;
    burst_pkg::blen_t       cnt_q;
    psram_pkg::addr_t       addr_q;

    logic                   head_is_hdr;
    logic                   hdr_write;
    burst_pkg::blen_t       hdr_len;
    psram_pkg::addr_t       hdr_addr;
    logic                   beat;
    logic                   in_burst;

    assign head_is_hdr = fifo.level != '0 && fifo.head_kind == burst_pkg::kind_hdr;
    assign hdr_write   = fifo.head_entry[burst_pkg::hdr_wr_bit];
    assign hdr_len     = fifo.head_entry[burst_pkg::hdr_len_lsb +: $bits(burst_pkg::blen_t)];
    assign hdr_addr    = fifo.head_entry[`PSRAM_ADDR_W-1:0];

    // wait drops in the first data cycle, so that cycle already moves a word
    assign beat = state == burst_pkg::st_burst ||
                  (state == burst_pkg::st_latency && !bus.wait_sig);
    assign in_burst = state == burst_pkg::st_addr ||
                      state == burst_pkg::st_latency ||
                      state == burst_pkg::st_burst;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= burst_pkg::st_idle;
            wr_q     <= 1'b0;
            cnt_q    <= '0;
            addr_q   <= '0;
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= beat && !wr_q;
            if (beat) begin
                cnt_q <= cnt_q - 1'b1;
            end
            case (state)
                burst_pkg::st_idle: begin
                    if (head_is_hdr) begin
                        wr_q   <= hdr_write;
                        cnt_q  <= hdr_len;
                        addr_q <= hdr_addr;
                        // writes wait until every data word is buffered
                        if (hdr_write && fifo.level <= burst_pkg::level_t'(hdr_len)) begin
                            state <= burst_pkg::st_wait_data;
                        end else begin
                            state <= burst_pkg::st_addr;
                        end
                    end
                end
                burst_pkg::st_wait_data: begin
                    if (fifo.level > burst_pkg::level_t'(cnt_q)) begin
                        state <= burst_pkg::st_addr;
                    end
                end
                burst_pkg::st_addr: begin
                    state <= burst_pkg::st_latency;
                end
                burst_pkg::st_latency, burst_pkg::st_burst: begin
                    if (beat) begin
                        if (cnt_q == 1) begin
                            state <= burst_pkg::st_release;
                        end else begin
                            state <= burst_pkg::st_burst;
                        end
                    end
                end
                default: begin
                    state <= burst_pkg::st_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (beat && !wr_q) begin
            rd_data <= bus.dq_in;
        end
    end

    assign bus.addr   = addr_q;
    assign bus.ce_n   = !in_burst;
    assign bus.adv_n  = state != burst_pkg::st_addr;
    assign bus.we_n   = !(in_burst && wr_q);
    assign bus.oe_n   = !(in_burst && !wr_q && state != burst_pkg::st_addr);
    assign bus.dq_out = fifo.head_entry;
    assign bus.dq_oe  = beat && wr_q;

    // header leaves in the address cycle, data words one per write beat
    assign fifo.pop = state == burst_pkg::st_addr || (beat && wr_q);

    a_wr_head_data : assert property (@(posedge clk) disable iff (!rst_n)
        beat && wr_q |-> fifo.level != '0 && fifo.head_kind == burst_pkg::kind_data);

endmodule

//--- psram_model.sv
`include "psram_cfg.svh"

module psram_model (
    input  logic clk,
    input  logic rst_n,
    psram_if.mem bus
);

    psram_pkg::mem_state_t state;
    psram_pkg::lat_cnt_t   lat_cnt;
    psram_pkg::addr_t      addr_cnt;
    psram_pkg::data_t      mem_q [`PSRAM_WORDS];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= psram_pkg::mem_idle;
            lat_cnt  <= '0;
            addr_cnt <= '0;
        end else begin
            case (state)
                psram_pkg::mem_idle: begin
                    lat_cnt <= '0;
                    if (!bus.ce_n && !bus.adv_n) begin
                        addr_cnt <= bus.addr;
                        if (bus.we_n) begin
                            state <= psram_pkg::mem_wait_rd;
                        end else begin
                            state <= psram_pkg::mem_wait_wr;
                        end
                    end
                end
                psram_pkg::mem_wait_rd, psram_pkg::mem_wait_wr: begin
                    lat_cnt <= lat_cnt + 1'b1;
                    if (lat_cnt == psram_pkg::lat_cnt_t'(`PSRAM_LATENCY - 2)) begin
                        if (state == psram_pkg::mem_wait_rd) begin
                            state <= psram_pkg::mem_data_rd;
                        end else begin
                            state <= psram_pkg::mem_data_wr;
                        end
                    end
                end
                psram_pkg::mem_data_rd, psram_pkg::mem_data_wr: begin
                    // address wraps from the top word back to zero
                    if (bus.ce_n) begin
                        state <= psram_pkg::mem_idle;
                    end else begin
                        addr_cnt <= addr_cnt + 1'b1;
                    end
                end
                default: begin
                    state <= psram_pkg::mem_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `PSRAM_WORDS; i++) begin
                mem_q[i] <= '0;
            end
        end else if (state == psram_pkg::mem_data_wr && !bus.ce_n && bus.dq_oe) begin
            mem_q[addr_cnt] <= bus.dq_out;
        end
    end

    assign bus.wait_sig = state == psram_pkg::mem_wait_rd || state == psram_pkg::mem_wait_wr;
    assign bus.dq_in    = (state == psram_pkg::mem_data_rd && !bus.oe_n) ? mem_q[addr_cnt] : '0;

    // controller must not drive the bus while the device drives it
    a_no_drive_on_read : assert property (@(posedge clk) disable iff (!rst_n)
        (state == psram_pkg::mem_wait_rd || state == psram_pkg::mem_data_rd) |-> !bus.dq_oe);

endmodule

//--- psram_sys.sv
module psram_sys (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             cmd_start,
    input  logic             cmd_write,
    input  psram_pkg::addr_t cmd_addr,
    input  burst_pkg::blen_t cmd_len,
    input  logic             wr_strobe,
    input  psram_pkg::data_t wr_data,
    output logic             busy,
    output logic             rd_valid,
    output psram_pkg::data_t rd_data
);

    burst_fifo_if fifo_bus ();
    psram_if      mem_bus ();

    host_cmd_port host_cmd_port_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_start (cmd_start),
        .cmd_write (cmd_write),
        .cmd_addr  (cmd_addr),
        .cmd_len   (cmd_len),
        .wr_strobe (wr_strobe),
        .wr_data   (wr_data),
        .busy      (busy),
        .fifo      (fifo_bus.producer)
    );

    burst_fifo burst_fifo_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .fifo  (fifo_bus.buffer)
    );

    psram_bus_ctrl psram_bus_ctrl_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .fifo     (fifo_bus.consumer),
        .bus      (mem_bus.ctrl),
        .rd_valid (rd_valid),
        .rd_data  (rd_data)
    );

    psram_model psram_model_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (mem_bus.mem)
    );

endmodule

//--- tb_psram_sys.sv
`include "psram_cfg.svh"

module tb_psram_sys;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int clk_period    = 4;
    localparam int n_directed    = 5;
    localparam int n_random      = 48;
    localparam int n_gapped      = 8;
    localparam int n_cmds        = n_directed + n_random + 2 * n_gapped;
    // reset, idle window and drain on top of the per-command budget
    localparam int margin_cycles = 60;
    localparam int wd_cycles     =
        n_cmds * (`MAX_BURST + `PSRAM_LATENCY + 4) + margin_cycles;
    // a full buffer of queued bursts still finishes within this
    localparam int drain_cycles  =
        `FIFO_DEPTH * (`MAX_BURST + `PSRAM_LATENCY + 4);

    logic             clk;
    logic             rst_n;
    logic             cmd_start;
    logic             cmd_write;
    psram_pkg::addr_t cmd_addr;
    burst_pkg::blen_t cmd_len;
    logic             wr_strobe;
    psram_pkg::data_t wr_data;
    logic             busy;
    logic             rd_valid;
    psram_pkg::data_t rd_data;

    logic [15:0]      lfsr_state;
    psram_pkg::data_t ref_mem [`PSRAM_WORDS];
    psram_pkg::data_t exp_q [$];
    psram_pkg::addr_t exp_addr_q [$];

    psram_sys psram_sys_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_start (cmd_start),
        .cmd_write (cmd_write),
        .cmd_addr  (cmd_addr),
        .cmd_len   (cmd_len),
        .wr_strobe (wr_strobe),
        .wr_data   (wr_data),
        .busy      (busy),
        .rd_valid  (rd_valid),
        .rd_data   (rd_data)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // galois form, taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 16'hB400;
        end else begin
            return s >> 1;
        end
    endfunction

    function automatic int unsigned take_bits(input int n);
        int unsigned v;
        int          k;
        v = 0;
        for (k = 0; k < n; k++) begin
            v = (v << 1) | 32'(lfsr_state[0]);
            lfsr_state = lfsr_step(lfsr_state);
        end
        return v;
    endfunction

    task automatic stop_on_failure(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input logic [31:0] got, input logic [31:0] expected,
                               input string what);
        string line;
        if (got !== expected) begin
            line = $sformatf("mismatch at %0t: %s, got 0x%0h, expected 0x%0h",
                             $time, what, got, expected);
            stop_on_failure(line);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic send_command(input logic write, input psram_pkg::addr_t addr,
                                input burst_pkg::blen_t len);
        while (busy) begin
            next_cycle();
        end
        cmd_start = 1'b1;
        cmd_write = write;
        cmd_addr  = addr;
        cmd_len   = len;
        next_cycle();
        cmd_start = 1'b0;
        cmd_write = 1'b0;
    endtask

    task automatic issue_write(input psram_pkg::addr_t addr, input burst_pkg::blen_t len,
                               input bit gapped);
        psram_pkg::data_t words [`MAX_BURST];
        int               i;
        for (i = 0; i < int'(len); i++) begin
            words[i] = psram_pkg::data_t'(take_bits(16));
        end
        send_command(1'b1, addr, len);
        // reference follows the address counter, wrapping at the top
        for (i = 0; i < int'(len); i++) begin
            ref_mem[addr + psram_pkg::addr_t'(i)] = words[i];
        end
        for (i = 0; i < int'(len); i++) begin
            if (gapped) begin
                repeat (take_bits(1)) next_cycle();
            end
            wr_strobe = 1'b1;
            wr_data   = words[i];
            next_cycle();
            wr_strobe = 1'b0;
        end
    endtask

    task automatic issue_read(input psram_pkg::addr_t addr, input burst_pkg::blen_t len);
        psram_pkg::addr_t a;
        int               i;
        for (i = 0; i < int'(len); i++) begin
            a = addr + psram_pkg::addr_t'(i);
            exp_q.push_back(ref_mem[a]);
            exp_addr_q.push_back(a);
        end
        send_command(1'b0, addr, len);
    endtask

    always @(negedge clk) begin : read_monitor
        psram_pkg::data_t want;
        psram_pkg::addr_t where;
        if (rst_n && rd_valid) begin
            if (exp_q.size() == 0) begin
                stop_on_failure("a read word came back while no read was outstanding");
            end else begin
                want  = exp_q.pop_front();
                where = exp_addr_q.pop_front();
                check_value(32'(rd_data), 32'(want),
                            $sformatf("read word from address %0d", where));
            end
        end
    end

    initial begin : watchdog
        #(wd_cycles * clk_period);
        stop_on_failure($sformatf("watchdog expired after %0d cycles, the DUT seems to hang",
                                  wd_cycles));
    end

    initial begin : stimulus
        int               i;
        int               drain;
        psram_pkg::addr_t a;
        burst_pkg::blen_t n;
        rst_n      = 1'b0;
        cmd_start  = 1'b0;
        cmd_write  = 1'b0;
        cmd_addr   = '0;
        cmd_len    = '0;
        wr_strobe  = 1'b0;
        wr_data    = '0;
        lfsr_state = 16'd16;
        drain      = 0;
        for (i = 0; i < `PSRAM_WORDS; i++) begin
            ref_mem[i] = '0;
        end
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // quiet after reset
        repeat (10) begin
            next_cycle();
            check_value(32'(busy), 0, "busy while idle");
            check_value(32'(rd_valid), 0, "rd_valid while idle");
        end

        issue_write(6'd17, 4'd1, 1'b0);
        issue_read(6'd17, 4'd1);
        issue_read(6'd42, 4'd1);
        // bursts across the top of the array
        issue_write(6'd60, 4'd8, 1'b0);
        issue_read(6'd62, 4'd5);

        for (i = 0; i < n_random; i++) begin
            a = psram_pkg::addr_t'(take_bits(6));
            n = burst_pkg::blen_t'(take_bits(3) + 1);
            if (take_bits(1) == 1) begin
                issue_write(a, n, 1'b0);
            end else begin
                issue_read(a, n);
            end
        end

        // write words with idle gaps, then read them back
        for (i = 0; i < n_gapped; i++) begin
            a = psram_pkg::addr_t'(take_bits(6));
            n = burst_pkg::blen_t'(take_bits(3) + 1);
            issue_write(a, n, 1'b1);
            issue_read(a, n);
        end

        while (exp_q.size() != 0 && drain < drain_cycles) begin
            next_cycle();
            drain++;
        end
        // catch late or repeated words
        repeat (12) next_cycle();

        if (exp_q.size() != 0) begin
            stop_on_failure("read words were still missing at the end of the run");
        end else begin
            $display("TESTS PASSED");
            $finish;
        end
    end

endmodule

//--- psram_sys.f
+incdir+.
psram_pkg.sv
burst_pkg.sv
burst_fifo_if.sv
psram_if.sv
host_cmd_port.sv
burst_fifo.sv
psram_bus_ctrl.sv
psram_model.sv
psram_sys.sv
tb_psram_sys.sv

//--- Makefile
VERILATOR  ?= verilator
FILELIST   ?= psram_sys.f
TB_TOP     ?= tb_psram_sys
RTL_TOP    ?= psram_sys
OBJ_DIR    ?= obj_dir
TIMESCALE  ?= 1ns/100ps
LINT_FLAGS ?= -Wall
SIM_FLAGS  ?= --binary --timing --assert -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) --timing --timescale $(TIMESCALE) \
		-f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) --timescale $(TIMESCALE) -f $(FILELIST) \
		--top-module $(TB_TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP) 2>&1)"; echo "$$out"; \
		echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)
